//--- Bender.yml
package:
  name: ex_stage

sources:
  - logic/ex_pkg.sv
  - logic/alu.sv
  - logic/mul_ctrl_fsm.sv
  - logic/mul_step_counter.sv
  - logic/mul_datapath.sv
  - logic/ex_wb_ports.sv
  - logic/ex_stage.sv
  - target: test
    files:
      - verif/ex_stage_assert.sv
      - verif/ex_stage_tb.sv

//--- flist.f
logic/ex_pkg.sv
logic/alu.sv
logic/mul_ctrl_fsm.sv
logic/mul_step_counter.sv
logic/mul_datapath.sv
logic/ex_wb_ports.sv
logic/ex_stage.sv
verif/ex_stage_assert.sv
verif/ex_stage_tb.sv

//--- logic/alu.sv
// Purely combinational, shift amount taken from the low 5 bits of operand b
// Unused op codes return zero
`timescale 1ns/1ps

module alu (
  input  ex_pkg::alu_req_t req_i,
  output ex_pkg::word_t    result_o,
  output logic             cmp_result_o
);

  logic        is_eq;
  logic        is_lts;
  logic        is_ltu;
  logic [4:0]  shamt;

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  assign is_eq  = (req_i.a == req_i.b);
  assign is_lts = ($signed(req_i.a) < $signed(req_i.b));
  assign is_ltu = (req_i.a < req_i.b);

  // Branch decision and set-less-than share this bit
  always_comb begin
    case (req_i.op)
      ex_pkg::ALU_EQ:   cmp_result_o = is_eq;
      ex_pkg::ALU_NE:   cmp_result_o = ~is_eq;
      ex_pkg::ALU_LTS,
      ex_pkg::ALU_SLTS: cmp_result_o = is_lts;
      ex_pkg::ALU_GES:  cmp_result_o = ~is_lts;
      ex_pkg::ALU_LTU,
      ex_pkg::ALU_SLTU: cmp_result_o = is_ltu;
      default:          cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////

  assign shamt = req_i.b[4:0];

  always_comb begin
    case (req_i.op)
      ex_pkg::ALU_ADD: result_o = req_i.a + req_i.b;
      ex_pkg::ALU_SUB: result_o = req_i.a - req_i.b;
      ex_pkg::ALU_AND: result_o = req_i.a & req_i.b;
      ex_pkg::ALU_OR:  result_o = req_i.a | req_i.b;
      ex_pkg::ALU_XOR: result_o = req_i.a ^ req_i.b;
      ex_pkg::ALU_SLL: result_o = req_i.a << shamt;
      ex_pkg::ALU_SRL: result_o = req_i.a >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::ALU_SRA: result_o = ex_pkg::word_t'($signed(req_i.a) >>> shamt);
      // Comparisons give zero or one
      ex_pkg::ALU_SLTS,
      ex_pkg::ALU_SLTU,
      ex_pkg::ALU_EQ,
      ex_pkg::ALU_NE,
      ex_pkg::ALU_LTS,
      ex_pkg::ALU_GES,
      ex_pkg::ALU_LTU: result_o = {31'b0, cmp_result_o};
      default:         result_o = '0;
    endcase
  end

endmodule

//--- logic/ex_pkg.sv
// Shared types of the execute stage, RV32 words and 6-bit register addresses
// Multiplier radix default must divide 32 evenly
package ex_pkg;

  // Register data word
  typedef logic [31:0] word_t;
  // Register file address, upper bit kept as in the core
  typedef logic [5:0]  reg_addr_t;

  // ALU operations
  // Comparison ops drive the branch decision
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLTS = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LTS  = 4'd12,
    ALU_GES  = 4'd13,
    ALU_LTU  = 4'd14
  } alu_op_e;

  // Multiply result word, unsigned product only
  typedef enum logic {
    MUL_LO = 1'b0,
    MUL_HU = 1'b1
  } mul_op_e;

  // Multiplier sequencer states
  typedef enum logic [1:0] {
    MUL_IDLE = 2'd0,
    MUL_RUN  = 2'd1,
    MUL_DONE = 2'd2
  } mul_state_e;

  // ALU request from ID, 68 bits
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
  } alu_req_t;

  // Multiplier request from ID, 65 bits
  typedef struct packed {
    mul_op_e op;
    word_t   a;
    word_t   b;
  } mul_req_t;

  // Register file write port, 39 bits
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_wr_t;

  // Product bits retired per multiplier step
  localparam int unsigned MUL_BITS_PER_STEP_DEF = 2;

endpackage

//--- logic/ex_stage.sv
// Execute stage with ALU and multicycle unsigned multiplier
// MUL_BITS_PER_STEP must divide 32, ID holds operands until ex_ready_o
`timescale 1ns/1ps

module ex_stage #(
  parameter int unsigned MUL_BITS_PER_STEP = ex_pkg::MUL_BITS_PER_STEP_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  input  ex_pkg::alu_req_t  alu_req_i,
  input  logic              alu_en_i,
  input  ex_pkg::word_t     alu_operand_c_i,
  input  ex_pkg::mul_req_t  mul_req_i,
  input  logic              mul_en_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              lsu_ready_ex_i,
  input  logic              branch_in_ex_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  input  logic              wb_ready_i,
  output ex_pkg::rf_wr_t    rf_alu_fw_o,
  output ex_pkg::rf_wr_t    rf_wb_o,
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,
  output logic              mul_multicycle_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  localparam int unsigned MUL_STEPS = 32 / MUL_BITS_PER_STEP;

  ex_pkg::word_t alu_result;
  ex_pkg::word_t mul_result;
  logic          mul_load;
  logic          mul_step;
  logic          mul_last_step;
  logic          mul_ready;

  ////////////////////////////////////////
  // ALU and branch
  ////////////////////////////////////////

  alu alu_i (
    .req_i        (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Jump target is computed in ID
  assign jump_target_o = alu_operand_c_i;

  ////////////////////////////////////////
  // Multiplier
  ////////////////////////////////////////

  mul_ctrl_fsm mul_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .mul_en_i     (mul_en_i),
    .last_step_i  (mul_last_step),
    .ex_ready_i   (ex_ready_o),
    .load_o       (mul_load),
    .step_o       (mul_step),
    .ready_o      (mul_ready),
    .multicycle_o (mul_multicycle_o)
  );

  mul_step_counter #(.NUM_STEPS(MUL_STEPS)) mul_cnt_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_i      (mul_load),
    .step_i      (mul_step),
    .last_step_o (mul_last_step)
  );

  mul_datapath #(.BITS_PER_STEP(MUL_BITS_PER_STEP)) mul_dp_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .load_i   (mul_load),
    .step_i   (mul_step),
    .req_i    (mul_req_i),
    .result_o (mul_result)
  );

  ////////////////////////////////////////
  // Write ports
  ////////////////////////////////////////

  ex_wb_ports ports_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ex_valid_i          (ex_valid_o),
    .wb_ready_i          (wb_ready_i),
    .alu_en_i            (alu_en_i),
    .mul_en_i            (mul_en_i),
    .csr_access_i        (csr_access_i),
    .alu_result_i        (alu_result),
    .mul_result_i        (mul_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .rf_alu_fw_o         (rf_alu_fw_o),
    .rf_wb_o             (rf_wb_o)
  );

  // Branches finish in EX, so they never wait on WB
  assign ex_ready_o = (mul_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  // Valid does not look at ready, it flows forward only
  assign ex_valid_o = (alu_en_i | mul_en_i | csr_access_i | lsu_en_i)
                      & mul_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

//--- logic/ex_wb_ports.sv
// Forwarding port is combinational, load port enable and address are registered
// Load data comes straight from the LSU in the WB cycle
`timescale 1ns/1ps

module ex_wb_ports (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_valid_i,
  input  logic              wb_ready_i,
  input  logic              alu_en_i,
  input  logic              mul_en_i,
  input  logic              csr_access_i,
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mul_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,
  output ex_pkg::rf_wr_t    rf_alu_fw_o,
  output ex_pkg::rf_wr_t    rf_wb_o
);

  logic              we_lsu_q;
  ex_pkg::reg_addr_t waddr_lsu_q;

  ////////////////////////////////////////
  // Forwarding write port
  ////////////////////////////////////////

  always_comb begin
    rf_alu_fw_o.we   = regfile_alu_we_i;
    rf_alu_fw_o.addr = regfile_alu_waddr_i;
    // CSR wins over multiplier, multiplier over ALU
    if (csr_access_i) begin
      rf_alu_fw_o.data = csr_rdata_i;
    end else if (mul_en_i) begin
      rf_alu_fw_o.data = mul_result_i;
    end else if (alu_en_i) begin
      rf_alu_fw_o.data = alu_result_i;
    end else begin
      rf_alu_fw_o.data = '0;
    end
  end

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_lsu_q    <= 1'b0;
      waddr_lsu_q <= '0;
    end else if (ex_valid_i) begin
      we_lsu_q <= regfile_we_i;
      // Address only moves with a real write
      if (regfile_we_i) begin
        waddr_lsu_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Bubble into WB
      we_lsu_q <= 1'b0;
    end
  end

  assign rf_wb_o.we   = we_lsu_q;
  assign rf_wb_o.addr = waddr_lsu_q;
  assign rf_wb_o.data = lsu_rdata_i;

endmodule

//--- logic/mul_ctrl_fsm.sv
// Sequences one multiply per request, the request level is held by ID
`timescale 1ns/1ps

module mul_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic mul_en_i,
  input  logic last_step_i,
  input  logic ex_ready_i,
  output logic load_o,
  output logic step_o,
  output logic ready_o,
  output logic multicycle_o
);

  ex_pkg::mul_state_e state_q;
  ex_pkg::mul_state_e state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      // Operands latched on the leaving edge
      ex_pkg::MUL_IDLE: if (mul_en_i) state_d = ex_pkg::MUL_RUN;
      ex_pkg::MUL_RUN:  if (last_step_i) state_d = ex_pkg::MUL_DONE;
      // Held here while the pipe is stalled
      ex_pkg::MUL_DONE: if (ex_ready_i) state_d = ex_pkg::MUL_IDLE;
      default:          state_d = ex_pkg::MUL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MUL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign load_o       = (state_q == ex_pkg::MUL_IDLE) & mul_en_i;
  assign step_o       = (state_q == ex_pkg::MUL_RUN);
  // Not ready while a request waits in IDLE or steps are pending
  assign ready_o      = ((state_q == ex_pkg::MUL_IDLE) & ~mul_en_i)
                        | (state_q == ex_pkg::MUL_DONE);
  assign multicycle_o = (state_q != ex_pkg::MUL_IDLE);

endmodule

//--- logic/mul_datapath.sv
// Unsigned shift-add multiplier, BITS_PER_STEP must divide 32
// Result is valid once all steps have been applied
`timescale 1ns/1ps

module mul_datapath #(
  parameter int unsigned BITS_PER_STEP = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load_i,
  input  logic             step_i,
  input  ex_pkg::mul_req_t req_i,
  output ex_pkg::word_t    result_o
);

  logic [63:0]     mcand_q;
  logic [31:0]     mplier_q;
  logic [63:0]     acc_q;
  ex_pkg::mul_op_e op_q;
  logic [63:0]     partial;

  // Partial product for the next group of multiplier bits
  always_comb begin
    partial = '0;
    for (int i = 0; i < BITS_PER_STEP; i++) begin
      if (mplier_q[i]) begin
        partial = partial + (mcand_q << i);
      end
    end
  end

  // Operand shift registers
  always_ff @(posedge clk) begin
    if (load_i) begin
      mcand_q  <= {32'b0, req_i.a};
      mplier_q <= req_i.b;
    end else if (step_i) begin
      mcand_q  <= mcand_q << BITS_PER_STEP;
      mplier_q <= mplier_q >> BITS_PER_STEP;
    end
  end

  // Accumulator and the latched result select
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
      op_q  <= ex_pkg::MUL_LO;
    end else if (load_i) begin
      acc_q <= '0;
      op_q  <= req_i.op;
    end else if (step_i) begin
      acc_q <= acc_q + partial;
    end
  end

  assign result_o = (op_q == ex_pkg::MUL_HU) ? acc_q[63:32] : acc_q[31:0];

endmodule

//--- logic/mul_step_counter.sv
// Counts multiplier steps, NUM_STEPS of at least 1
`timescale 1ns/1ps

module mul_step_counter #(
  parameter int unsigned NUM_STEPS = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic load_i,
  input  logic step_i,
  output logic last_step_o
);

  localparam int unsigned CNT_W = (NUM_STEPS > 1) ? $clog2(NUM_STEPS) : 1;

  logic [CNT_W-1:0] cnt_q;

  // Restart on load, advance once per step
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= '0;
    end else if (step_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // High only during the final step
  assign last_step_o = step_i & (cnt_q == CNT_W'(NUM_STEPS - 1));

endmodule

//--- verif/ex_stage_assert.sv
// Bound into ex_stage and holds the reference models and all result checks
// Assumes ID holds each instruction until ex_ready_o and that the testbench reads err_cnt
`timescale 1ns/1ps

module ex_stage_assert #(
  parameter int unsigned BITS_PER_STEP = 2
) (
  input logic              clk,
  input logic              rst_n,
  input ex_pkg::alu_req_t  alu_req_i,
  input logic              alu_en_i,
  input ex_pkg::word_t     alu_operand_c_i,
  input ex_pkg::mul_req_t  mul_req_i,
  input logic              mul_en_i,
  input logic              csr_access_i,
  input ex_pkg::word_t     lsu_rdata_i,
  input logic              lsu_ready_ex_i,
  input logic              branch_in_ex_i,
  input logic              regfile_alu_we_i,
  input ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input logic              regfile_we_i,
  input ex_pkg::reg_addr_t regfile_waddr_i,
  input logic              wb_ready_i,
  input ex_pkg::rf_wr_t    rf_alu_fw_o,
  input ex_pkg::rf_wr_t    rf_wb_o,
  input ex_pkg::word_t     jump_target_o,
  input logic              branch_decision_o,
  input logic              mul_multicycle_o,
  input logic              ex_ready_o,
  input logic              ex_valid_o
);

  localparam int unsigned STEPS = 32 / BITS_PER_STEP;

  int                err_cnt = 0;
  ex_pkg::word_t     alu_exp;
  logic              cmp_exp;
  logic [63:0]       prod;
  ex_pkg::word_t     mul_exp;
  int unsigned       run_left_q;
  logic              in_done;
  ex_pkg::word_t     fw_data_q;
  ex_pkg::reg_addr_t waddr_q;

  ////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////

  // Signed order by flipping the sign bits before an unsigned compare
  function automatic logic cmp_ref(ex_pkg::alu_op_e op, ex_pkg::word_t a, ex_pkg::word_t b);
    logic lts;
    lts = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (op)
      ex_pkg::ALU_EQ:                    return a == b;
      ex_pkg::ALU_NE:                    return a != b;
      ex_pkg::ALU_LTS, ex_pkg::ALU_SLTS: return lts;
      ex_pkg::ALU_GES:                   return !lts;
      ex_pkg::ALU_LTU, ex_pkg::ALU_SLTU: return a < b;
      default:                           return 1'b0;
    endcase
  endfunction

  function automatic ex_pkg::word_t alu_ref(ex_pkg::alu_req_t r);
    logic [63:0] sext;
    // Sign extended to 64 bits so a logical shift gives the arithmetic one
    sext = {{32{r.a[31]}}, r.a} >> r.b[4:0];
    case (r.op)
      ex_pkg::ALU_ADD: return r.a + r.b;
      ex_pkg::ALU_SUB: return r.a + ~r.b + 32'd1;
      ex_pkg::ALU_AND: return r.a & r.b;
      ex_pkg::ALU_OR:  return r.a | r.b;
      ex_pkg::ALU_XOR: return r.a ^ r.b;
      ex_pkg::ALU_SLL: return r.a << r.b[4:0];
      ex_pkg::ALU_SRL: return r.a >> r.b[4:0];
      ex_pkg::ALU_SRA: return sext[31:0];
      ex_pkg::ALU_SLTS, ex_pkg::ALU_SLTU, ex_pkg::ALU_EQ, ex_pkg::ALU_NE,
      ex_pkg::ALU_LTS, ex_pkg::ALU_GES, ex_pkg::ALU_LTU:
        return {31'b0, cmp_ref(r.op, r.a, r.b)};
      default:         return '0;
    endcase
  endfunction

  assign alu_exp = alu_ref(alu_req_i);
  assign cmp_exp = cmp_ref(alu_req_i.op, alu_req_i.a, alu_req_i.b);
  assign prod    = {32'b0, mul_req_i.a} * {32'b0, mul_req_i.b};
  assign mul_exp = (mul_req_i.op == ex_pkg::MUL_HU) ? prod[63:32] : prod[31:0];

  // Steps still to run after a start seen in IDLE
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_left_q <= 0;
    end else if (mul_en_i && !mul_multicycle_o) begin
      run_left_q <= STEPS;
    end else if (run_left_q != 0) begin
      run_left_q <= run_left_q - 1;
    end
  end

  assign in_done = mul_multicycle_o && (run_left_q == 0);

  // Previous cycle copies
  always_ff @(posedge clk) begin
    fw_data_q <= rf_alu_fw_o.data;
    waddr_q   <= regfile_waddr_i;
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_alu_data: assert property (@(posedge clk) disable iff (!rst_n)
    alu_en_i && !mul_en_i && !csr_access_i |-> rf_alu_fw_o.data == alu_exp)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_alu_fw_o.data expected %h actual %h",
             $time, $sampled(alu_exp), $sampled(rf_alu_fw_o.data));
    end

  // Forwarding port carries the ID write enable and address unchanged
  a_fw_port: assert property (@(posedge clk) disable iff (!rst_n)
    rf_alu_fw_o.we == regfile_alu_we_i && rf_alu_fw_o.addr == regfile_alu_waddr_i)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_alu_fw_o we/addr expected %b/%h actual %b/%h",
             $time, $sampled(regfile_alu_we_i), $sampled(regfile_alu_waddr_i),
             $sampled(rf_alu_fw_o.we), $sampled(rf_alu_fw_o.addr));
    end

  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_decision_o == cmp_exp)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: branch_decision_o expected %b actual %b",
             $time, $sampled(cmp_exp), $sampled(branch_decision_o));
    end

  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    jump_target_o == alu_operand_c_i)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: jump_target_o expected %h actual %h",
             $time, $sampled(alu_operand_c_i), $sampled(jump_target_o));
    end

  a_mul_result: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && mul_en_i && !csr_access_i |-> rf_alu_fw_o.data == mul_exp)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_alu_fw_o.data expected %h actual %h",
             $time, $sampled(mul_exp), $sampled(rf_alu_fw_o.data));
    end

  // Stall of steps+1 cycles with the multicycle flag up from the second one
  a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
    mul_en_i && !mul_multicycle_o && !branch_in_ex_i |->
      !ex_ready_o ##1 (!ex_ready_o && mul_multicycle_o) [*STEPS]
      ##1 (mul_multicycle_o && ex_ready_o == (wb_ready_i && lsu_ready_ex_i)))
    else begin
      err_cnt++;
      $error("Multiply at %0t did not stall for exactly %0d cycles with mul_multicycle_o up",
             $time, STEPS + 1);
    end

  a_stall_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i |-> !ex_valid_o)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: ex_valid_o expected 0 actual %b", $time, $sampled(ex_valid_o));
    end

  a_stall_ready: assert property (@(posedge clk) disable iff (!rst_n)
    !wb_ready_i && !branch_in_ex_i |-> !ex_ready_o)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: ex_ready_o expected 0 actual %b", $time, $sampled(ex_ready_o));
    end

  a_mul_hold: assert property (@(posedge clk) disable iff (!rst_n)
    mul_en_i && !csr_access_i && in_done && !ex_ready_o |=> rf_alu_fw_o.data == fw_data_q)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_alu_fw_o.data expected %h actual %h",
             $time, $sampled(fw_data_q), $sampled(rf_alu_fw_o.data));
    end

  a_wb_capture: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && regfile_we_i |=> rf_wb_o.we && rf_wb_o.addr == waddr_q)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_wb_o we/addr expected 1/%h actual %b/%h",
             $time, $sampled(waddr_q), $sampled(rf_wb_o.we), $sampled(rf_wb_o.addr));
    end

  // Load data goes straight from the LSU to the load port
  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
    rf_wb_o.data == lsu_rdata_i)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_wb_o.data expected %h actual %h",
             $time, $sampled(lsu_rdata_i), $sampled(rf_wb_o.data));
    end

  a_wb_clear: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ready_i && !ex_valid_o |=> !rf_wb_o.we)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_wb_o.we expected 0 actual %b", $time, $sampled(rf_wb_o.we));
    end

  // First reset edge only clears the state so the check starts at the second one
  a_reset_state: assert property (@(posedge clk)
    !rst_n ##1 !rst_n |-> !rf_wb_o.we && !mul_multicycle_o)
    else begin
      err_cnt++;
      $error("Mismatch at %0t: rf_wb_o.we/mul_multicycle_o expected 0/0 actual %b/%b",
             $time, $sampled(rf_wb_o.we), $sampled(mul_multicycle_o));
    end

endmodule

bind ex_stage ex_stage_assert #(.BITS_PER_STEP(MUL_BITS_PER_STEP)) chk_i (.*);

//--- verif/ex_stage_tb.sv
// Random instruction mix into ex_stage, results checked by the bound assertions
// Fixed instruction count, every handshake wait bounded by READY_LIMIT cycles
`timescale 1ns/1ps

module ex_stage_tb;

  localparam int unsigned CLK_PERIOD  = 20;
  localparam int unsigned NUM_INSTR   = 400;
  localparam int unsigned READY_LIMIT = 100;

  logic              clk;
  logic              rst_n;
  ex_pkg::alu_req_t  alu_req;
  logic              alu_en;
  ex_pkg::word_t     operand_c;
  ex_pkg::mul_req_t  mul_req;
  logic              mul_en;
  logic              csr_access;
  ex_pkg::word_t     csr_rdata;
  logic              lsu_en;
  ex_pkg::word_t     lsu_rdata;
  logic              lsu_ready;
  logic              branch_in_ex;
  logic              regfile_alu_we;
  ex_pkg::reg_addr_t regfile_alu_waddr;
  logic              regfile_we;
  ex_pkg::reg_addr_t regfile_waddr;
  logic              wb_ready;
  ex_pkg::rf_wr_t    rf_alu_fw;
  ex_pkg::rf_wr_t    rf_wb;
  ex_pkg::word_t     jump_target;
  logic              branch_decision;
  logic              mul_multicycle;
  logic              ex_ready;
  logic              ex_valid;
  int unsigned       timeout_errs;

  ex_stage #(.MUL_BITS_PER_STEP(ex_pkg::MUL_BITS_PER_STEP_DEF)) uut (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_req_i           (alu_req),
    .alu_en_i            (alu_en),
    .alu_operand_c_i     (operand_c),
    .mul_req_i           (mul_req),
    .mul_en_i            (mul_en),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_ready_ex_i      (lsu_ready),
    .branch_in_ex_i      (branch_in_ex),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .wb_ready_i          (wb_ready),
    .rf_alu_fw_o         (rf_alu_fw),
    .rf_wb_o             (rf_wb),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .mul_multicycle_o    (mul_multicycle),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // WB drops one cycle in four
  function automatic logic pick_wb_ready();
    return $urandom_range(0, 3) != 0;
  endfunction

  task automatic clear_inputs();
    alu_req           = '0;
    alu_en            = 1'b0;
    operand_c         = '0;
    mul_req           = '0;
    mul_en            = 1'b0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    lsu_ready         = 1'b1;
    branch_in_ex      = 1'b0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    wb_ready          = 1'b1;
  endtask

  // Kinds: ALU, multiply, CSR read, load, branch, bubble
  task automatic drive_instr(int unsigned kind);
    clear_inputs();
    alu_req.op        = ex_pkg::alu_op_e'(4'($urandom_range(0, 14)));
    alu_req.a         = $urandom();
    // Equal operands now and then so EQ and GES both ways get hit
    alu_req.b         = ($urandom_range(0, 3) == 0) ? alu_req.a : $urandom();
    operand_c         = $urandom();
    mul_req.op        = ex_pkg::mul_op_e'($urandom_range(0, 1));
    mul_req.a         = $urandom();
    mul_req.b         = $urandom();
    csr_rdata         = $urandom();
    lsu_rdata         = $urandom();
    regfile_alu_waddr = 6'($urandom_range(0, 63));
    regfile_waddr     = 6'($urandom_range(0, 63));
    wb_ready          = pick_wb_ready();
    case (kind)
      0: begin
        alu_en         = 1'b1;
        regfile_alu_we = 1'b1;
      end
      1: begin
        mul_en         = 1'b1;
        regfile_alu_we = 1'b1;
      end
      2: begin
        csr_access     = 1'b1;
        regfile_alu_we = 1'b1;
      end
      3: begin
        lsu_en     = 1'b1;
        regfile_we = 1'b1;
      end
      4: begin
        alu_en       = 1'b1;
        branch_in_ex = 1'b1;
        alu_req.op   = ex_pkg::alu_op_e'(4'($urandom_range(10, 14)));
      end
      default: begin
      end
    endcase
  endtask

  // Keeps the instruction up until ex_ready is seen at a rising edge
  task automatic hold_until_ready(output bit ok);
    int unsigned cycles;
    bit          rdy;
    cycles = 0;
    rdy    = 1'b0;
    while (!rdy && cycles < READY_LIMIT) begin
      // Inputs moved on the falling edge, ready has settled a quarter period later
      #(CLK_PERIOD / 4);
      rdy = ex_ready;
      @(negedge clk);
      cycles++;
      if (!rdy) begin
        wb_ready = pick_wb_ready();
      end
    end
    ok = rdy;
    if (!rdy) begin
      timeout_errs++;
      $display("Timeout at %0t: ex_ready_o stayed low for %0d cycles", $time, READY_LIMIT);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    bit          ok;
    int unsigned kind;
    void'($urandom(71));
    clk          = 1'b0;
    rst_n        = 1'b0;
    timeout_errs = 0;
    clear_inputs();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    ok    = 1'b1;
    for (int n = 0; n < NUM_INSTR && ok; n++) begin
      kind = $urandom_range(0, 5);
      drive_instr(kind);
      hold_until_ready(ok);
    end
    // Let the one-cycle-later checks see the last instruction
    clear_inputs();
    repeat (3) @(negedge clk);
    $display("Run complete: %0d assertion errors, %0d timeout errors",
             uut.chk_i.err_cnt, timeout_errs);
    if (timeout_errs == 0 && uut.chk_i.err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
